//--- bench/rob_assertions.sv
`default_nettype none

module rob_assertions (
	input wire                                                     i_clk,
	input wire                                                     i_rst_n,
	input wire                                                     i_empty,
	input wire                                                     i_full,
	input wire rob_types_pkg::rob_commit_t [rob_cfg_pkg::NBANK-1:0] i_commit
);

	int fail_cnt = 0;
	logic [rob_cfg_pkg::NBANK-1:0] com_en;

	always_comb begin
		for (int b = 0; b < rob_cfg_pkg::NBANK; b++) begin
			com_en[b] = i_commit[b].com_en;
		end
	end

	a_commit_needs_rows: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(|com_en) |-> !i_empty)
	else begin
		fail_cnt++;
		$error("commit enable seen while the ring is empty");
	end

	a_full_not_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_full && i_empty))
	else begin
		fail_cnt++;
		$error("ring reports full and empty together");
	end

	// first edge after reset release
	a_quiet_after_reset: assert property (@(posedge i_clk) $rose(i_rst_n) |-> (com_en == '0))
	else begin
		fail_cnt++;
		$error("commit enable high right after reset");
	end

endmodule

bind rob_top rob_assertions m_asrt (
	.i_clk    (i_clk),
	.i_rst_n  (i_rst_n),
	.i_empty  (ring_empty),
	.i_full   (o_overflow),
	.i_commit (o_commit)
);

`default_nettype wire

//--- bench/rob_checker.sv
`default_nettype none

module rob_checker (
	input wire                                                      i_clk,
	input wire                                                      i_rst_n,
	input wire                                                      i_dis_we,
	input wire rob_types_pkg::rob_dispatch_t                        i_dis,
	input wire rob_types_pkg::rob_wb_t [rob_cfg_pkg::NWB-1:0]       i_wb,
	input wire [rob_cfg_pkg::KILL_BITS-1:0]                         i_brkill,
	input wire rob_types_pkg::rob_tag_u                             i_pc_tag,
	input wire [rob_cfg_pkg::ROW_BITS-1:0]                          i_dis_tag,
	input wire                                                      i_overflow,
	input wire rob_types_pkg::rob_commit_t [rob_cfg_pkg::NBANK-1:0] i_commit,
	input wire [31:0]                                               i_pc,
	output int                                                      o_errors,
	output int                                                      o_checks
);

	localparam int RB = rob_cfg_pkg::ROW_BITS;
	localparam int NB = rob_cfg_pkg::NBANK;
	localparam int SLOTS = rob_cfg_pkg::ROWS * NB;

	// flat slot index is row * NB + bank
	rob_types_pkg::rob_entry_t ent [SLOTS];
	rob_types_pkg::rob_commit_t [NB-1:0] exp_com;
	logic [rob_cfg_pkg::PC_HI_BITS-1:0] pc_hi [rob_cfg_pkg::ROWS];
	logic [rob_cfg_pkg::ROWS-1:0] pc_ok;
	logic [RB:0] head;
	logic [RB:0] tail;
	logic [RB:0] used;
	logic empty;
	logic full;
	logic retire;

	initial begin
		o_errors = 0;
		o_checks = 0;
	end

	always_comb begin
		rob_types_pkg::rob_entry_t e;

		used = tail - head;
		empty = (used == '0);
		full = used[RB];
		retire = !empty;
		for (int b = 0; b < NB; b++) begin
			e = ent[int'(head[RB-1:0]) * NB + b];
			if (e.val && e.busy) begin
				retire = 1'b0;
			end
		end
		for (int b = 0; b < NB; b++) begin
			e = ent[int'(head[RB-1:0]) * NB + b];
			exp_com[b].com_prd = e.val ? e.prd_old : e.prd_new;
			exp_com[b].com_en = retire && (exp_com[b].com_prd != '0);
		end
	end

	always @(posedge i_clk or negedge i_rst_n) begin
		logic accept;
		logic do_retire;

		accept = i_dis_we && !full;
		do_retire = retire;
		if (!i_rst_n) begin
			head = '0;
			tail = '0;
			pc_ok = '0;
			for (int i = 0; i < SLOTS; i++) begin
				ent[i].val = 1'b0;
				ent[i].busy = 1'b0;
			end
		end else begin
			for (int i = 0; i < SLOTS; i++) begin
				if (accept && (i / NB) == int'(tail[RB-1:0])) begin
					ent[i] = i_dis.ent[i % NB];
				end else begin
					for (int p = 0; p < rob_cfg_pkg::NWB; p++) begin
						if (i_wb[p].en && int'(i_wb[p].tag.idx) == i) begin
							ent[i].busy = 1'b0;
						end
					end
					if (|(ent[i].brmask & i_brkill[rob_cfg_pkg::BRM_BITS-1:0])) begin
						ent[i].val = 1'b0;
					end
				end
			end
			if (accept) begin
				pc_hi[tail[RB-1:0]] = i_dis.pc_hi;
				pc_ok[tail[RB-1:0]] = 1'b1;
				tail++;
			end
			if (do_retire) begin
				head++;
			end
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		o_checks++;
		if (got !== exp) begin
			o_errors++;
			$display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// outputs have settled by the falling edge
	always @(negedge i_clk) begin
		if (i_rst_n) begin
			check_value("o_dis_tag", 32'(i_dis_tag), 32'(tail[RB-1:0]));
			check_value("o_overflow", 32'(i_overflow), 32'(full));
			for (int b = 0; b < NB; b++) begin
				check_value($sformatf("o_commit[%0d].com_en", b),
					32'(i_commit[b].com_en), 32'(exp_com[b].com_en));
				if (retire) begin
					check_value($sformatf("o_commit[%0d].com_prd", b),
						32'(i_commit[b].com_prd), 32'(exp_com[b].com_prd));
				end
			end
			if (pc_ok[i_pc_tag.f.row]) begin
				check_value("o_pc", i_pc,
					{pc_hi[i_pc_tag.f.row], i_pc_tag.f.bank, 2'b00});
			end
		end
	end

endmodule

`default_nettype wire

//--- bench/rob_tb.sv
`default_nettype none

module rob_tb;

	localparam int PHASE_CYCLES = 300;
	localparam int NUM_PHASES = 5;
	localparam int CLK_PERIOD = 20;
	// twice the length of all phases
	localparam int TIMEOUT = NUM_PHASES * PHASE_CYCLES * CLK_PERIOD * 2;

	logic                                                i_clk;
	logic                                                i_rst_n;
	logic                                                i_dis_we;
	rob_types_pkg::rob_dispatch_t                        i_dis;
	rob_types_pkg::rob_wb_t [rob_cfg_pkg::NWB-1:0]       i_wb;
	logic [rob_cfg_pkg::KILL_BITS-1:0]                   i_brkill;
	rob_types_pkg::rob_tag_u                             i_pc_tag;
	logic [rob_cfg_pkg::ROW_BITS-1:0]                    o_dis_tag;
	logic                                                o_overflow;
	rob_types_pkg::rob_commit_t [rob_cfg_pkg::NBANK-1:0] o_commit;
	logic [31:0]                                         o_pc;

	int errors;
	int checks;
	int tests_run;
	int total_errors;

	rob_top UUT (.*);

	rob_checker m_check (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_dis_we   (i_dis_we),
		.i_dis      (i_dis),
		.i_wb       (i_wb),
		.i_brkill   (i_brkill),
		.i_pc_tag   (i_pc_tag),
		.i_dis_tag  (o_dis_tag),
		.i_overflow (o_overflow),
		.i_commit   (o_commit),
		.i_pc       (o_pc),
		.o_errors   (errors),
		.o_checks   (checks)
	);

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	function automatic rob_types_pkg::rob_entry_t random_entry(input int test_no);
		rob_types_pkg::rob_entry_t e;
		logic [31:0] r;

		r = $urandom;
		e.val = (test_no == 5) ? 1'b1 : (r[2:0] != 3'd0);
		e.busy = (test_no == 3 || test_no == 5) ? 1'b1 : (r[4:3] != 2'd0);
		e.uop = r[11:5];
		e.prd_old = (test_no == 6 && r[30]) ? 7'd0 : r[18:12];
		e.prd_new = (test_no == 6 && r[31]) ? 7'd0 : r[25:19];
		e.brmask = (test_no == 4) ? r[29:26] : 4'd0;
		return e;
	endfunction

	task automatic idle_inputs();
		i_dis_we = 1'b0;
		i_dis = '0;
		i_wb = '0;
		i_brkill = '0;
		i_pc_tag = '0;
	endtask

	task automatic drive_inputs(input int test_no, input int cyc);
		logic [31:0] r;
		logic hold_wb;

		// full-buffer test starves writeback for half of each 60-cycle window
		hold_wb = (test_no == 5) && ((cyc % 60) < 30);
		r = $urandom;
		i_dis_we = (test_no == 5) ? 1'b1 : (r[0] | r[1]);
		i_dis.pc_hi = r[31:4];
		for (int b = 0; b < rob_cfg_pkg::NBANK; b++) begin
			i_dis.ent[b] = random_entry(test_no);
		end
		for (int p = 0; p < rob_cfg_pkg::NWB; p++) begin
			r = $urandom;
			i_wb[p].en = r[0] & ~hold_wb;
			i_wb[p].tag.idx = r[5:1];
		end
		r = $urandom;
		i_brkill = (test_no == 4 && r[2:0] == 3'd0) ? r[31:16] : '0;
		i_pc_tag.idx = r[8:4];
	endtask

	task automatic report_test(input int test_no, input string name, input int errs_before);
		tests_run++;
		$display("test %0d (%s) finished with %0d errors", test_no, name,
			errors - errs_before);
	endtask

	task automatic run_phase(input int test_no, input string name);
		int errs_before;

		errs_before = errors;
		for (int cyc = 0; cyc < PHASE_CYCLES; cyc++) begin
			@(posedge i_clk);
			#2;
			drive_inputs(test_no, cyc);
		end
		@(posedge i_clk);
		#2;
		idle_inputs();
		report_test(test_no, name, errs_before);
	endtask

	initial begin
		int errs_before;

		void'($urandom(32'hc83ca201));
		tests_run = 0;
		i_clk = 1'b0;
		i_rst_n = 1'b0;
		idle_inputs();
		repeat (3) @(posedge i_clk);
		#2;
		i_rst_n = 1'b1;

		// inputs stay idle, the checker sees the reset state
		errs_before = errors;
		repeat (4) @(posedge i_clk);
		report_test(1, "reset state", errs_before);

		run_phase(2, "dispatch and pc lookup");
		run_phase(3, "writeback and in-order commit");
		run_phase(4, "branch kill");
		run_phase(5, "full buffer");
		run_phase(6, "register zero");

		total_errors = errors + UUT.m_asrt.fail_cnt;
		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, total_errors);
		if (total_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT);
		$display("watchdog expired before the tests finished");
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/rob_bank.sv
`default_nettype none

module rob_bank (
	input  wire                                  i_clk,
	input  wire                                  i_rst_n,
	input  wire rob_types_pkg::rob_bank_ctl_t    i_ctl,
	input  wire [rob_cfg_pkg::ROW_BITS-1:0]      i_tail,
	input  wire [rob_cfg_pkg::ROW_BITS-1:0]      i_head,
	input  wire [rob_cfg_pkg::KILL_BITS-1:0]     i_brkill,
	output rob_types_pkg::rob_entry_t            o_head_entry
);

	// everything below val and busy
	localparam int PAY_BITS = $bits(rob_types_pkg::rob_entry_t) - 2;

	rob_types_pkg::rob_entry_t slot_ent [rob_cfg_pkg::ROWS];

	for (genvar r = 0; r < rob_cfg_pkg::ROWS; r++) begin : g_slot
		localparam logic [rob_cfg_pkg::ROW_BITS-1:0] ROW = r;

		logic                val_q;
		logic                busy_q;
		logic [PAY_BITS-1:0] pay_q;
		logic                load;
		logic                kill_hit;

		assign slot_ent[r] = {val_q, busy_q, pay_q};

		assign load = i_ctl.we && (i_tail == ROW);
		// mask bit b lines up with kill bit b
		assign kill_hit = |(slot_ent[r].brmask & i_brkill[rob_cfg_pkg::BRM_BITS-1:0]);

		always_ff @(posedge i_clk or negedge i_rst_n) begin
			if (!i_rst_n) begin
				val_q <= 1'b0;
				busy_q <= 1'b0;
			end else if (load) begin
				val_q <= i_ctl.ent.val;
				busy_q <= i_ctl.ent.busy;
			end else begin
				if (i_ctl.busy_clr[r]) begin
					busy_q <= 1'b0;
				end
				if (kill_hit) begin
					val_q <= 1'b0;
				end
			end
		end

		always_ff @(posedge i_clk) begin
			if (load) begin
				pay_q <= i_ctl.ent[PAY_BITS-1:0];
			end
		end
	end

	assign o_head_entry = slot_ent[i_head];

endmodule

`default_nettype wire

//--- hdl/rob_cfg_pkg.sv
`default_nettype none

package rob_cfg_pkg;

	localparam int NBANK = 4;
	localparam int BANK_BITS = $clog2(NBANK);
	// writeback ports, one per issue lane
	localparam int NWB = 4;

	localparam int ROW_BITS = 3;
	localparam int ROWS = 1 << ROW_BITS;
	localparam int TAG_BITS = ROW_BITS + BANK_BITS;

	localparam int REG_BITS = 7;
	localparam int UOP_BITS = 7;

	localparam int BRM_BITS = 4;
	localparam int KILL_BITS = 1 << BRM_BITS;

	// pc bits 31..4, the low bits come from bank and byte offset
	localparam int PC_HI_BITS = 28;

endpackage

`default_nettype wire

//--- hdl/rob_commit.sv
`default_nettype none

module rob_commit (
	input  wire rob_types_pkg::rob_entry_t [rob_cfg_pkg::NBANK-1:0]   i_head_entry,
	input  wire                                                       i_empty,
	output logic                                                      o_retire,
	output rob_types_pkg::rob_commit_t [rob_cfg_pkg::NBANK-1:0]       o_commit
);

	logic [rob_cfg_pkg::NBANK-1:0] blocked;

	// a live entry still waiting on writeback holds the row
	always_comb begin
		for (int b = 0; b < rob_cfg_pkg::NBANK; b++) begin
			blocked[b] = i_head_entry[b].val & i_head_entry[b].busy;
		end
	end

	assign o_retire = ~i_empty & ~|blocked;

	always_comb begin
		logic [rob_cfg_pkg::REG_BITS-1:0] prd;

		prd = '0;
		for (int b = 0; b < rob_cfg_pkg::NBANK; b++) begin
			// killed entry gives back its own new mapping
			prd = i_head_entry[b].val ? i_head_entry[b].prd_old : i_head_entry[b].prd_new;
			o_commit[b].com_prd = prd;
			// p0 is hardwired, never freed
			o_commit[b].com_en = o_retire & (|prd);
		end
	end

endmodule

`default_nettype wire

//--- hdl/rob_dispatch_split.sv
`default_nettype none

module rob_dispatch_split (
	input  wire rob_types_pkg::rob_dispatch_t                         i_dis,
	input  wire                                                       i_accept,
	input  wire rob_types_pkg::rob_wb_t [rob_cfg_pkg::NWB-1:0]        i_wb,
	output rob_types_pkg::rob_bank_ctl_t [rob_cfg_pkg::NBANK-1:0]     o_ctl
);

	always_comb begin
		o_ctl = '0;
		for (int b = 0; b < rob_cfg_pkg::NBANK; b++) begin
			o_ctl[b].we = i_accept;
			o_ctl[b].ent = i_dis.ent[b];
			// several ports may land in one bank, their rows are or-ed
			for (int p = 0; p < rob_cfg_pkg::NWB; p++) begin
				if (i_wb[p].en && int'(i_wb[p].tag.f.bank) == b) begin
					o_ctl[b].busy_clr[i_wb[p].tag.f.row] = 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/rob_ring_ctrl.sv
`default_nettype none

module rob_ring_ctrl (
	input  wire                                  i_clk,
	input  wire                                  i_rst_n,
	input  wire                                  i_dis_we,
	input  wire [rob_cfg_pkg::PC_HI_BITS-1:0]    i_pc_hi,
	input  wire                                  i_retire,
	input  wire rob_types_pkg::rob_tag_u         i_pc_tag,
	output logic [rob_cfg_pkg::ROW_BITS-1:0]     o_head,
	output logic [rob_cfg_pkg::ROW_BITS-1:0]     o_tail,
	output logic                                 o_accept,
	output logic                                 o_empty,
	output logic                                 o_full,
	output logic [31:0]                          o_pc
);

	// msb is the wrap bit
	logic [rob_cfg_pkg::ROW_BITS:0] head_q;
	logic [rob_cfg_pkg::ROW_BITS:0] tail_q;

	logic [rob_cfg_pkg::PC_HI_BITS-1:0] pc_ring [rob_cfg_pkg::ROWS];

	assign o_head = head_q[rob_cfg_pkg::ROW_BITS-1:0];
	assign o_tail = tail_q[rob_cfg_pkg::ROW_BITS-1:0];

	assign o_empty = (head_q == tail_q);
	// same row, different lap
	assign o_full = (head_q[rob_cfg_pkg::ROW_BITS] != tail_q[rob_cfg_pkg::ROW_BITS]) &&
		(o_head == o_tail);

	assign o_accept = i_dis_we & ~o_full;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			head_q <= '0;
			tail_q <= '0;
		end else begin
			if (o_accept) begin
				tail_q <= tail_q + 1'b1;
			end
			if (i_retire) begin
				head_q <= head_q + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_accept) begin
			pc_ring[o_tail] <= i_pc_hi;
		end
	end

	// row picks the fetch block, bank picks the word in it
	assign o_pc = {pc_ring[i_pc_tag.f.row], i_pc_tag.f.bank, 2'b00};

endmodule

`default_nettype wire

//--- hdl/rob_top.sv
`default_nettype none

module rob_top (
	input  wire                                                 i_clk,
	input  wire                                                 i_rst_n,
	input  wire                                                 i_dis_we,
	input  wire rob_types_pkg::rob_dispatch_t                   i_dis,
	input  wire rob_types_pkg::rob_wb_t [rob_cfg_pkg::NWB-1:0]  i_wb,
	input  wire [rob_cfg_pkg::KILL_BITS-1:0]                    i_brkill,
	input  wire rob_types_pkg::rob_tag_u                        i_pc_tag,
	output logic [rob_cfg_pkg::ROW_BITS-1:0]                    o_dis_tag,
	output logic                                                o_overflow,
	output rob_types_pkg::rob_commit_t [rob_cfg_pkg::NBANK-1:0] o_commit,
	output logic [31:0]                                         o_pc
);

	logic [rob_cfg_pkg::ROW_BITS-1:0] head;
	logic [rob_cfg_pkg::ROW_BITS-1:0] tail;
	logic                             accept;
	logic                             ring_empty;
	logic                             retire;

	rob_types_pkg::rob_bank_ctl_t [rob_cfg_pkg::NBANK-1:0] bank_ctl;
	rob_types_pkg::rob_entry_t [rob_cfg_pkg::NBANK-1:0]    head_ent;

	assign o_dis_tag = tail;

	rob_ring_ctrl m_ring (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_dis_we (i_dis_we),
		.i_pc_hi  (i_dis.pc_hi),
		.i_retire (retire),
		.i_pc_tag (i_pc_tag),
		.o_head   (head),
		.o_tail   (tail),
		.o_accept (accept),
		.o_empty  (ring_empty),
		.o_full   (o_overflow),
		.o_pc     (o_pc)
	);

	rob_dispatch_split m_split (
		.i_dis    (i_dis),
		.i_accept (accept),
		.i_wb     (i_wb),
		.o_ctl    (bank_ctl)
	);

	for (genvar b = 0; b < rob_cfg_pkg::NBANK; b++) begin : g_bank
		rob_bank m_bank (
			.i_clk        (i_clk),
			.i_rst_n      (i_rst_n),
			.i_ctl        (bank_ctl[b]),
			.i_tail       (tail),
			.i_head       (head),
			.i_brkill     (i_brkill),
			.o_head_entry (head_ent[b])
		);
	end

	rob_commit m_commit (
		.i_head_entry (head_ent),
		.i_empty      (ring_empty),
		.o_retire     (retire),
		.o_commit     (o_commit)
	);

endmodule

`default_nettype wire

//--- hdl/rob_types_pkg.sv
`default_nettype none

package rob_types_pkg;

	typedef struct packed {
		logic                             val;
		logic                             busy;
		logic [rob_cfg_pkg::UOP_BITS-1:0] uop;
		logic [rob_cfg_pkg::REG_BITS-1:0] prd_old;
		logic [rob_cfg_pkg::REG_BITS-1:0] prd_new;
		logic [rob_cfg_pkg::BRM_BITS-1:0] brmask;
	} rob_entry_t;

	// one row, entry b goes to bank b
	typedef struct packed {
		rob_entry_t [rob_cfg_pkg::NBANK-1:0] ent;
		logic [rob_cfg_pkg::PC_HI_BITS-1:0]  pc_hi;
	} rob_dispatch_t;

	typedef struct packed {
		logic [rob_cfg_pkg::ROW_BITS-1:0]  row;
		logic [rob_cfg_pkg::BANK_BITS-1:0] bank;
	} rob_tag_fields_t;

	// flat index is row * NBANK + bank
	typedef union packed {
		logic [rob_cfg_pkg::TAG_BITS-1:0] idx;
		rob_tag_fields_t                  f;
	} rob_tag_u;

	typedef struct packed {
		logic     en;
		rob_tag_u tag;
	} rob_wb_t;

	typedef struct packed {
		logic                         we;
		logic [rob_cfg_pkg::ROWS-1:0] busy_clr;
		rob_entry_t                   ent;
	} rob_bank_ctl_t;

	typedef struct packed {
		logic                             com_en;
		logic [rob_cfg_pkg::REG_BITS-1:0] com_prd;
	} rob_commit_t;

endpackage

`default_nettype wire

//--- rob.f
hdl/rob_cfg_pkg.sv
hdl/rob_types_pkg.sv
hdl/rob_ring_ctrl.sv
hdl/rob_dispatch_split.sv
hdl/rob_bank.sv
hdl/rob_commit.sv
hdl/rob_top.sv
bench/rob_assertions.sv
bench/rob_checker.sv
bench/rob_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the reorder buffer testbench with Verilator, runs it and scans the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f rob.f --top-module rob_tb -o Vrob_tb

./obj_dir/Vrob_tb +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
	echo "run_sim: FAIL"
	exit 1
fi
echo "run_sim: PASS"
